/* source/output_bus_pkg.sv */
`default_nettype none

package output_bus_pkg;

    localparam int NUM_EDGE_PE = 4;
    localparam int NUM_VERTEX_UNIT = 4;
    localparam int NUM_BANKS = 4;
    localparam int NUM_WR_REQS = NUM_EDGE_PE + NUM_VERTEX_UNIT;
    localparam int NUM_REQS = NUM_EDGE_PE + NUM_WR_REQS;
    localparam int FV_BANDWIDTH = 64;
    localparam int MAX_NODE_ID = 1024;
    localparam int BANK_IDX_W = $clog2(NUM_BANKS);

    typedef logic [$clog2(MAX_NODE_ID)-1:0] node_id_t;
    typedef logic [BANK_IDX_W-1:0] bank_idx_t;
    typedef logic [$clog2(NUM_EDGE_PE)-1:0] pe_tag_t;
    typedef logic [FV_BANDWIDTH-1:0] fv_data_t;
    typedef logic [NUM_REQS-1:0] req_vec_t;
    typedef logic [NUM_BANKS-1:0] bank_vec_t;

    // edge PE read requester
    typedef struct packed {
        logic grant_valid;
        pe_tag_t pe_tag;
        logic req;
        node_id_t node_id;
    } pe_rd_req_t;

    // edge or vertex bank write streamer
    typedef struct packed {
        logic grant_valid;
        logic sos;
        logic eos;
        fv_data_t data;
        logic req;
        node_id_t node_id;
    } wr_stream_req_t;

    // rd_wr is 0 for read and 1 for write
    typedef struct packed {
        logic valid;
        pe_tag_t pe_tag;
        logic rd_wr;
        node_id_t node_id;
        fv_data_t data;
        logic wr_sos;
        logic wr_eos;
    } bank_cmd_t;

    // banks are interleaved on the low node id bits
    function automatic bank_idx_t bank_of(node_id_t node_id);
        return node_id[BANK_IDX_W-1:0];
    endfunction

endpackage

`default_nettype wire

/* source/rr_grant_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_grant_arbiter
    import output_bus_pkg::*;
#(
    parameter int num_reqs = NUM_REQS
) (
    input  wire logic clk,
    input  wire logic reset,
    input  req_vec_t  reqs,
    output req_vec_t  grants
);

    localparam int PTR_W = $clog2(num_reqs);

    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] winner;
    logic [PTR_W-1:0] ptr_nx;
    logic found;
    req_vec_t grants_nx;

    // first request at or after the pointer with wraparound
    always_comb begin
        int idx;
        grants_nx = '0;
        winner = '0;
        found = 1'b0;
        for (int i = 0; i < num_reqs; i++) begin
            idx = int'(ptr_q) + i;
            if (idx >= num_reqs) begin
                idx = idx - num_reqs;
            end
            if (!found && reqs[idx]) begin
                found = 1'b1;
                winner = PTR_W'(idx);
            end
        end
        if (found) begin
            grants_nx[winner] = 1'b1;
        end
    end

    // pointer goes one past the winner
    always_comb begin
        if (winner == PTR_W'(num_reqs - 1)) begin
            ptr_nx = '0;
        end else begin
            ptr_nx = winner + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grants <= '0;
            ptr_q <= '0;
        end else begin
            grants <= grants_nx;
            if (found) begin
                ptr_q <= ptr_nx;
            end
        end
    end

    // at most one grant per cycle
    grants_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(grants)
    ) else $error("rr_grant_arbiter: grants not one-hot: %b", grants);

endmodule

`default_nettype wire

/* source/bank_lock_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_lock_tracker
    import output_bus_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             reset,
    input  req_vec_t              reqs,
    input  node_id_t              node_ids [NUM_REQS],
    input  wire logic [NUM_WR_REQS-1:0] wr_eos,
    input  bank_vec_t             bank_eos,
    input  req_vec_t              grants,
    output req_vec_t              masked_reqs
);

    // bank each requester was aiming at when its grant was issued
    bank_idx_t target_q [NUM_REQS];

    bank_vec_t lock_q;
    bank_vec_t lock_set;
    bank_vec_t lock_nx;

    // locked banks plus the bank of the grant being shown now
    always_comb begin
        lock_set = lock_q;
        for (int i = 0; i < NUM_REQS; i++) begin
            if (grants[i]) begin
                lock_set[target_q[i]] = 1'b1;
            end
        end
    end

    always_comb begin
        masked_reqs = '0;
        for (int i = 0; i < NUM_REQS; i++) begin
            masked_reqs[i] = reqs[i] & ~lock_set[bank_of(node_ids[i])];
        end
    end

    // releases only act on the next cycle's masking
    always_comb begin
        lock_nx = lock_set & ~bank_eos;
        for (int j = 0; j < NUM_WR_REQS; j++) begin
            if (wr_eos[j]) begin
                lock_nx[bank_of(node_ids[NUM_EDGE_PE + j])] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_q <= '0;
        end else begin
            lock_q <= lock_nx;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_REQS; i++) begin
            target_q[i] <= bank_of(node_ids[i]);
        end
    end

    // the bank of a new grant was neither locked nor just granted a cycle ago
    for (genvar i = 0; i < NUM_REQS; i++) begin : g_lock_chk
        no_grant_to_locked: assert property (
            @(posedge clk) disable iff (reset)
            grants[i] |-> ($past(lock_set) & (bank_vec_t'(1) << target_q[i])) == '0
        ) else $error("bank_lock_tracker: requester %0d granted a locked bank", i);
    end

endmodule

`default_nettype wire

/* source/bank_cmd_router.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_cmd_router
    import output_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  pe_rd_req_t    pe_reqs [NUM_EDGE_PE],
    input  wr_stream_req_t edge_wr_reqs [NUM_EDGE_PE],
    input  wr_stream_req_t vertex_wr_reqs [NUM_VERTEX_UNIT],
    output bank_cmd_t     bank_cmd [NUM_BANKS]
);

    bank_cmd_t cmd_nx [NUM_BANKS];

    // read beat carries the PE tag and no data
    function automatic bank_cmd_t rd_cmd(pe_rd_req_t r);
        bank_cmd_t c;
        c = '0;
        c.valid = 1'b1;
        c.pe_tag = r.pe_tag;
        c.rd_wr = 1'b0;
        c.node_id = r.node_id;
        return c;
    endfunction

    function automatic bank_cmd_t wr_cmd(wr_stream_req_t w);
        bank_cmd_t c;
        c = '0;
        c.valid = 1'b1;
        c.rd_wr = 1'b1;
        c.node_id = w.node_id;
        c.data = w.data;
        c.wr_sos = w.sos;
        c.wr_eos = w.eos;
        return c;
    endfunction

    // scanned in requester order so a higher index overrides
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            cmd_nx[b] = '0;
        end
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            if (pe_reqs[i].grant_valid) begin
                cmd_nx[bank_of(pe_reqs[i].node_id)] = rd_cmd(pe_reqs[i]);
            end
        end
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            if (edge_wr_reqs[i].grant_valid) begin
                cmd_nx[bank_of(edge_wr_reqs[i].node_id)] = wr_cmd(edge_wr_reqs[i]);
            end
        end
        for (int i = 0; i < NUM_VERTEX_UNIT; i++) begin
            if (vertex_wr_reqs[i].grant_valid) begin
                cmd_nx[bank_of(vertex_wr_reqs[i].node_id)] = wr_cmd(vertex_wr_reqs[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_cmd[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_cmd[b] <= cmd_nx[b];
            end
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_route_chk
        cmd_in_own_bank: assert property (
            @(posedge clk) disable iff (reset)
            bank_cmd[b].valid |-> bank_of(bank_cmd[b].node_id) == bank_idx_t'(b)
        ) else $error("bank_cmd_router: bank %0d holds node %0d",
                      b, bank_cmd[b].node_id);
    end

endmodule

`default_nettype wire

/* source/output_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module output_bus_arbiter
    import output_bus_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  pe_rd_req_t     pe_reqs [NUM_EDGE_PE],
    input  wr_stream_req_t edge_wr_reqs [NUM_EDGE_PE],
    input  wr_stream_req_t vertex_wr_reqs [NUM_VERTEX_UNIT],
    input  bank_vec_t      bank_eos,
    output bank_cmd_t      bank_cmd [NUM_BANKS],
    output req_vec_t       grants
);

    req_vec_t all_reqs;
    req_vec_t masked_reqs;
    node_id_t all_node_ids [NUM_REQS];
    logic [NUM_WR_REQS-1:0] wr_eos;

    // requester order is edge PEs, then edge banks, then vertex banks
    for (genvar i = 0; i < NUM_EDGE_PE; i++) begin : g_pe
        assign all_reqs[i] = pe_reqs[i].req;
        assign all_node_ids[i] = pe_reqs[i].node_id;
    end

    for (genvar i = 0; i < NUM_EDGE_PE; i++) begin : g_edge_wr
        assign all_reqs[NUM_EDGE_PE + i] = edge_wr_reqs[i].req;
        assign all_node_ids[NUM_EDGE_PE + i] = edge_wr_reqs[i].node_id;
        assign wr_eos[i] = edge_wr_reqs[i].eos;
    end

    for (genvar i = 0; i < NUM_VERTEX_UNIT; i++) begin : g_vertex_wr
        assign all_reqs[2 * NUM_EDGE_PE + i] = vertex_wr_reqs[i].req;
        assign all_node_ids[2 * NUM_EDGE_PE + i] = vertex_wr_reqs[i].node_id;
        assign wr_eos[NUM_EDGE_PE + i] = vertex_wr_reqs[i].eos;
    end

    bank_lock_tracker u_lock (
        .clk         (clk),
        .reset       (reset),
        .reqs        (all_reqs),
        .node_ids    (all_node_ids),
        .wr_eos      (wr_eos),
        .bank_eos    (bank_eos),
        .grants      (grants),
        .masked_reqs (masked_reqs)
    );

    rr_grant_arbiter #(
        .num_reqs (NUM_REQS)
    ) u_arb (
        .clk    (clk),
        .reset  (reset),
        .reqs   (masked_reqs),
        .grants (grants)
    );

    bank_cmd_router u_router (
        .clk            (clk),
        .reset          (reset),
        .pe_reqs        (pe_reqs),
        .edge_wr_reqs   (edge_wr_reqs),
        .vertex_wr_reqs (vertex_wr_reqs),
        .bank_cmd       (bank_cmd)
    );

endmodule

`default_nettype wire

/* tb/output_bus_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module output_bus_checker
    import output_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  pe_rd_req_t    pe_reqs [NUM_EDGE_PE],
    input  wr_stream_req_t edge_wr_reqs [NUM_EDGE_PE],
    input  wr_stream_req_t vertex_wr_reqs [NUM_VERTEX_UNIT],
    input  bank_vec_t     bank_eos,
    input  bank_cmd_t     bank_cmd [NUM_BANKS],
    input  req_vec_t      grants,
    output int            error_count,
    output int            grant_count
);

    int errors = 0;
    int grants_seen = 0;

    // model state for the cycle that has just ended
    req_vec_t exp_grants;
    bank_vec_t lock_reg;
    bank_vec_t prev_lock_set;
    bank_cmd_t exp_cmd [NUM_BANKS];
    int ptr;
    int grant_bank;

    assign error_count = errors;
    assign grant_count = grants_seen;

    // bank interleave is node id modulo bank count
    function automatic int bank_sel(node_id_t n);
        return int'(n) % NUM_BANKS;
    endfunction

    function automatic wr_stream_req_t writer(int j);
        if (j < NUM_EDGE_PE) begin
            return edge_wr_reqs[j];
        end
        return vertex_wr_reqs[j - NUM_EDGE_PE];
    endfunction

    function automatic logic req_of(int i);
        wr_stream_req_t w;
        if (i < NUM_EDGE_PE) begin
            return pe_reqs[i].req;
        end
        w = writer(i - NUM_EDGE_PE);
        return w.req;
    endfunction

    function automatic node_id_t node_of(int i);
        wr_stream_req_t w;
        if (i < NUM_EDGE_PE) begin
            return pe_reqs[i].node_id;
        end
        w = writer(i - NUM_EDGE_PE);
        return w.node_id;
    endfunction

    task automatic report_mismatch(string name, logic [95:0] exp_val, logic [95:0] act_val);
        errors++;
        $display("mismatch %s: expected %h actual %h", name, exp_val, act_val);
    endtask

    always @(posedge clk) begin
        bank_vec_t lock_set;
        bank_vec_t lock_nx;
        req_vec_t masked;
        bank_cmd_t c;
        wr_stream_req_t w;
        int winner;
        int idx;
        if (reset) begin
            exp_grants = '0;
            lock_reg = '0;
            prev_lock_set = '0;
            ptr = 0;
            grant_bank = 0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                exp_cmd[b] = '0;
            end
        end else begin
            if (grants !== exp_grants) begin
                report_mismatch("grants", 96'(exp_grants), 96'(grants));
            end
            if (!$onehot0(grants)) begin
                errors++;
                $display("grants has more than one bit set: %b", grants);
            end
            for (int i = 0; i < NUM_REQS; i++) begin
                if (grants[i] && prev_lock_set[bank_sel(node_of(i))]) begin
                    errors++;
                    $display("requester %0d granted while bank %0d was locked",
                             i, bank_sel(node_of(i)));
                end
            end
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (bank_cmd[b] !== exp_cmd[b]) begin
                    report_mismatch($sformatf("bank_cmd[%0d]", b),
                                    96'(exp_cmd[b]), 96'(bank_cmd[b]));
                end
            end
            grants_seen += $countones(grants);

            // a visible grant already locks its bank
            lock_set = lock_reg;
            if (exp_grants != '0) begin
                lock_set[grant_bank] = 1'b1;
            end
            masked = '0;
            for (int i = 0; i < NUM_REQS; i++) begin
                masked[i] = req_of(i) && !lock_set[bank_sel(node_of(i))];
            end
            winner = -1;
            for (int k = 0; k < NUM_REQS; k++) begin
                idx = (ptr + k) % NUM_REQS;
                if (winner < 0 && masked[idx]) begin
                    winner = idx;
                end
            end
            exp_grants = '0;
            if (winner >= 0) begin
                exp_grants[winner] = 1'b1;
                grant_bank = bank_sel(node_of(winner));
                ptr = (winner + 1) % NUM_REQS;
            end

            lock_nx = lock_set & ~bank_eos;
            for (int j = 0; j < NUM_WR_REQS; j++) begin
                w = writer(j);
                if (w.grant_valid && w.eos) begin
                    lock_nx[bank_sel(w.node_id)] = 1'b0;
                end
            end
            prev_lock_set = lock_set;
            lock_reg = lock_nx;

            // later requesters overwrite earlier ones on the same bank
            for (int b = 0; b < NUM_BANKS; b++) begin
                exp_cmd[b] = '0;
            end
            for (int i = 0; i < NUM_EDGE_PE; i++) begin
                if (pe_reqs[i].grant_valid) begin
                    c = '0;
                    c.valid = 1'b1;
                    c.pe_tag = pe_reqs[i].pe_tag;
                    c.node_id = pe_reqs[i].node_id;
                    exp_cmd[bank_sel(pe_reqs[i].node_id)] = c;
                end
            end
            for (int j = 0; j < NUM_WR_REQS; j++) begin
                w = writer(j);
                if (w.grant_valid) begin
                    c = '0;
                    c.valid = 1'b1;
                    c.rd_wr = 1'b1;
                    c.node_id = w.node_id;
                    c.data = w.data;
                    c.wr_sos = w.sos;
                    c.wr_eos = w.eos;
                    exp_cmd[bank_sel(w.node_id)] = c;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_output_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_output_bus_arbiter
    import output_bus_pkg::*;
();

    localparam int RUN_CYCLES = 2000;
    localparam int GRANT_TIMEOUT = 1000;
    localparam int DRAIN_TIMEOUT = 3000;
    localparam int RESET_TIMEOUT = 100;

    logic clk;
    logic reset;
    logic stop;
    pe_rd_req_t pe_reqs [NUM_EDGE_PE];
    wr_stream_req_t edge_wr_reqs [NUM_EDGE_PE];
    wr_stream_req_t vertex_wr_reqs [NUM_VERTEX_UNIT];
    bank_vec_t bank_eos;
    bank_cmd_t bank_cmd [NUM_BANKS];
    req_vec_t grants;

    bank_vec_t rd_eos [NUM_EDGE_PE];
    int req_misses [NUM_REQS];
    logic [NUM_REQS-1:0] finished;
    int error_count;
    int grant_count;

    output_bus_arbiter uut (
        .clk            (clk),
        .reset          (reset),
        .pe_reqs        (pe_reqs),
        .edge_wr_reqs   (edge_wr_reqs),
        .vertex_wr_reqs (vertex_wr_reqs),
        .bank_eos       (bank_eos),
        .bank_cmd       (bank_cmd),
        .grants         (grants)
    );

    output_bus_checker u_checker (
        .clk            (clk),
        .reset          (reset),
        .pe_reqs        (pe_reqs),
        .edge_wr_reqs   (edge_wr_reqs),
        .vertex_wr_reqs (vertex_wr_reqs),
        .bank_eos       (bank_eos),
        .bank_cmd       (bank_cmd),
        .grants         (grants),
        .error_count    (error_count),
        .grant_count    (grant_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // readers release their bank through the SRAM end-of-stream pulse
    always_comb begin
        bank_eos = '0;
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            bank_eos = bank_eos | rd_eos[i];
        end
    end

    for (genvar i = 0; i < NUM_EDGE_PE; i++) begin : g_reader
        pe_rd_req_t r;
        bank_vec_t eos_pulse;
        int misses;
        logic done;

        assign pe_reqs[i] = r;
        assign rd_eos[i] = eos_pulse;
        assign req_misses[i] = misses;
        assign finished[i] = done;

        initial begin
            int cnt;
            int bank;
            r = '0;
            r.pe_tag = pe_tag_t'(i);
            eos_pulse = '0;
            misses = 0;
            done = 1'b0;
            cnt = 0;
            while (reset !== 1'b0 && cnt < RESET_TIMEOUT) begin
                @(posedge clk);
                cnt++;
            end
            while (!stop) begin
                r.node_id <= node_id_t'($urandom);
                r.req <= 1'b1;
                cnt = 0;
                @(posedge clk);
                while (!grants[i] && cnt < GRANT_TIMEOUT) begin
                    @(posedge clk);
                    cnt++;
                end
                r.req <= 1'b0;
                if (!grants[i]) begin
                    $display("requester %0d never granted", i);
                    misses++;
                    break;
                end
                bank = int'(r.node_id) % NUM_BANKS;
                repeat ($urandom_range(0, 3)) @(posedge clk);
                r.grant_valid <= 1'b1;
                @(posedge clk);
                r.grant_valid <= 1'b0;
                repeat ($urandom_range(0, 3)) @(posedge clk);
                eos_pulse[bank] <= 1'b1;
                @(posedge clk);
                eos_pulse[bank] <= 1'b0;
                repeat ($urandom_range(0, 3)) @(posedge clk);
            end
            done <= 1'b1;
        end
    end

    // edge bank writers come before vertex bank writers
    for (genvar j = 0; j < NUM_WR_REQS; j++) begin : g_writer
        wr_stream_req_t w;
        int misses;
        logic done;

        if (j < NUM_EDGE_PE) begin : g_edge
            assign edge_wr_reqs[j] = w;
        end else begin : g_vertex
            assign vertex_wr_reqs[j - NUM_EDGE_PE] = w;
        end
        assign req_misses[NUM_EDGE_PE + j] = misses;
        assign finished[NUM_EDGE_PE + j] = done;

        initial begin
            int cnt;
            int beats;
            w = '0;
            misses = 0;
            done = 1'b0;
            cnt = 0;
            while (reset !== 1'b0 && cnt < RESET_TIMEOUT) begin
                @(posedge clk);
                cnt++;
            end
            while (!stop) begin
                w.node_id <= node_id_t'($urandom);
                w.req <= 1'b1;
                cnt = 0;
                @(posedge clk);
                while (!grants[NUM_EDGE_PE + j] && cnt < GRANT_TIMEOUT) begin
                    @(posedge clk);
                    cnt++;
                end
                w.req <= 1'b0;
                if (!grants[NUM_EDGE_PE + j]) begin
                    $display("requester %0d never granted", NUM_EDGE_PE + j);
                    misses++;
                    break;
                end
                repeat ($urandom_range(0, 3)) @(posedge clk);
                beats = $urandom_range(1, 4);
                for (int k = 0; k < beats; k++) begin
                    w.grant_valid <= 1'b1;
                    w.sos <= (k == 0);
                    w.eos <= (k == beats - 1);
                    w.data <= {$urandom, $urandom};
                    @(posedge clk);
                end
                w.grant_valid <= 1'b0;
                w.sos <= 1'b0;
                w.eos <= 1'b0;
                repeat ($urandom_range(0, 3)) @(posedge clk);
            end
            done <= 1'b1;
        end
    end

    initial begin
        int cnt;
        int total_misses;
        logic drain_fail;
        void'($urandom(71));
        reset = 1'b1;
        stop = 1'b0;
        drain_fail = 1'b0;
        total_misses = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (RUN_CYCLES) @(posedge clk);
        stop <= 1'b1;
        cnt = 0;
        while (finished != '1 && cnt < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (finished != '1) begin
            $display("requesters still busy after the drain timeout: %b", finished);
            drain_fail = 1'b1;
        end
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM_REQS; i++) begin
            total_misses += req_misses[i];
        end
        if (grant_count == 0) begin
            $display("no grant was ever observed");
        end
        $display("errors: %0d mismatches, %0d grant timeouts, %0d drain timeouts (%0d grants)",
                 error_count, total_misses, drain_fail, grant_count);
        if (error_count == 0 && total_misses == 0 && !drain_fail && grant_count > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/output_bus_pkg.sv
source/rr_grant_arbiter.sv
source/bank_lock_tracker.sv
source/bank_cmd_router.sv
source/output_bus_arbiter.sv
tb/output_bus_checker.sv
tb/tb_output_bus_arbiter.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_output_bus_arbiter -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed or did not build"; exit 1; }
